//--- hw/oflow_macros.svh
/* optical flow history buffer sizes
   slot count, lines per slot and field widths */
`ifndef OFLOW_MACROS_SVH
`define OFLOW_MACROS_SVH

// ------------------------------
// storage geometry
// ------------------------------

// frame slots in the history ring
`define OFLOW_HIST_SLOTS 5

// lines per slot
`define OFLOW_LINE_DEPTH 64

// bits per stored line word
`define OFLOW_LINE_WIDTH 32

// ------------------------------
// field widths
// ------------------------------

// serial number of a frame, wraps at 256
`define OFLOW_FRAME_NUM_WIDTH 8

// history count or slot index
`define OFLOW_HIST_WIDTH 3

// line offset inside one slot
`define OFLOW_OFFSET_WIDTH 6

// line count, one bit wider than the offset so 64 fits
`define OFLOW_COUNT_WIDTH 7

`endif

//--- hw/oflow_pkg.sv
/* optical flow history buffer types
   field vectors, request structs and the read FSM states */
`default_nettype none

`include "oflow_macros.svh"

package oflow_pkg;

	// ------------------------------
	// plain field vectors
	// ------------------------------

	// frame serial number
	typedef logic [`OFLOW_FRAME_NUM_WIDTH-1:0] frame_num_t;
	// number of history frames
	typedef logic [`OFLOW_HIST_WIDTH-1:0] hist_cnt_t;
	// slot index in the ring
	typedef logic [`OFLOW_HIST_WIDTH-1:0] slot_t;
	// line offset inside a slot
	typedef logic [`OFLOW_OFFSET_WIDTH-1:0] offset_t;
	// lines held by a stored frame
	typedef logic [`OFLOW_COUNT_WIDTH-1:0] line_cnt_t;
	// one line word
	typedef logic [`OFLOW_LINE_WIDTH-1:0] line_t;

	// end pointer per slot, slot 0 in the low bits
	typedef line_cnt_t [`OFLOW_HIST_SLOTS-1:0] end_ptrs_t;

	// ------------------------------
	// memory requests
	// ------------------------------

	// write side, slot + offset + data
	typedef struct packed {
		slot_t   slot;
		offset_t offset;
		line_t   data;
	} wr_req_t;

	// read side, address only
	typedef struct packed {
		slot_t   slot;
		offset_t offset;
	} rd_req_t;

	// read sequencer states
	typedef enum logic [1:0] {
		idle_st,
		frame_st,
		offset_st
	} read_state_t;

endpackage

`default_nettype wire

//--- hw/oflow_frame_writer.sv
/* history frame writer
   stores incoming lines in the frame's ring slot and keeps per-slot end pointers */
`timescale 1ns/10ps
`default_nettype none

`include "oflow_macros.svh"

module oflow_frame_writer (
	input  logic                   clk,
	input  logic                   reset_N,
	// levels, stable during a frame
	input  oflow_pkg::frame_num_t  frame_num,
	input  oflow_pkg::hist_cnt_t   num_of_history_frames,
	// incoming line strobe
	input  logic                   line_in_valid,
	input  oflow_pkg::line_t       line_in,
	// closes the current frame
	input  logic                   frame_end,
	// to slot memory
	output logic                   wr_en,
	output oflow_pkg::wr_req_t     wr_req,
	// to read sequencer
	output oflow_pkg::end_ptrs_t   end_ptrs
);

	// ------------------------------
	// signals
	// ------------------------------

	oflow_pkg::slot_t     wr_slot;
	oflow_pkg::line_cnt_t line_cnt;
	oflow_pkg::line_cnt_t cnt_next;
	logic                 accept;

	// slot of the frame being written
	assign wr_slot = oflow_pkg::slot_t'(frame_num % num_of_history_frames);

	// drop lines once the slot is full
	assign accept = line_in_valid &&
		(line_cnt < oflow_pkg::line_cnt_t'(`OFLOW_LINE_DEPTH));

	// count including a line accepted this cycle
	assign cnt_next = line_cnt + oflow_pkg::line_cnt_t'(accept);

	// ------------------------------
	// write port
	// ------------------------------

	// memory writes on the next edge
	assign wr_en         = accept;
	assign wr_req.slot   = wr_slot;
	// running count is the offset of the next line
	assign wr_req.offset = oflow_pkg::offset_t'(line_cnt);
	assign wr_req.data   = line_in;

	// ------------------------------
	// line counter
	// ------------------------------

	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			line_cnt <= '0;
		end else if (frame_end) begin
			// next frame starts at offset 0
			line_cnt <= '0;
		end else begin
			line_cnt <= cnt_next;
		end
	end

	// end pointers, one per slot
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			end_ptrs <= '0;
		end else if (frame_end) begin
			end_ptrs[wr_slot] <= cnt_next;
		end
	end

	// ------------------------------
	// checks
	// ------------------------------

	// source must stop at slot depth
	a_no_overflow: assert property (@(posedge clk) disable iff (!reset_N)
		(line_cnt == oflow_pkg::line_cnt_t'(`OFLOW_LINE_DEPTH)) |-> !line_in_valid)
		else $error("ERR line_in_valid past slot depth, frame_num=%h", frame_num);

	// ring size must fit the slot array while writing
	a_hist_range: assert property (@(posedge clk) disable iff (!reset_N)
		(line_in_valid || frame_end) |->
		(num_of_history_frames >= 1 && num_of_history_frames <= `OFLOW_HIST_SLOTS))
		else $error("ERR num_of_history_frames=%h out of range", num_of_history_frames);

endmodule

`default_nettype wire

//--- hw/oflow_frame_mem.sv
/* history slot memory
   slot by line array, one write port and a registered read port */
`timescale 1ns/10ps
`default_nettype none

`include "oflow_macros.svh"

module oflow_frame_mem (
	input  logic                clk,
	input  logic                reset_N,
	// write side from frame writer
	input  logic                wr_en,
	input  oflow_pkg::wr_req_t  wr_req,
	// read side from sequencer
	input  logic                rd_en,
	input  oflow_pkg::rd_req_t  rd_req,
	// one cycle after rd_en
	output oflow_pkg::line_t    rd_data,
	output logic                rd_valid
);

	// ------------------------------
	// storage
	// ------------------------------

	oflow_pkg::line_t mem_array [`OFLOW_HIST_SLOTS][`OFLOW_LINE_DEPTH];

	// write port
	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem_array[wr_req.slot][wr_req.offset] <= wr_req.data;
		end
	end

	// registered read, old data on same-address write
	always_ff @(posedge clk) begin
		if (rd_en) begin
			rd_data <= mem_array[rd_req.slot][rd_req.offset];
		end
	end

	// valid flag follows rd_en by one cycle
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			rd_valid <= 1'b0;
		end else begin
			rd_valid <= rd_en;
		end
	end

	// ------------------------------
	// checks
	// ------------------------------

	// both ports stay inside the slot array
	a_slot_range: assert property (@(posedge clk) disable iff (!reset_N)
		(wr_en || rd_en) |->
		((!wr_en || wr_req.slot < `OFLOW_HIST_SLOTS) &&
		(!rd_en || rd_req.slot < `OFLOW_HIST_SLOTS)))
		else $error("ERR slot out of range, wr_slot=%h rd_slot=%h",
			wr_req.slot, rd_req.slot);

endmodule

`default_nettype wire

//--- hw/oflow_fsm_read.sv
/* history read sequencer
   walks history frames newest first, one line per consumer request */
`timescale 1ns/10ps
`default_nettype none

module oflow_fsm_read (
	input  logic                   clk,
	input  logic                   reset_N,
	// levels, stable while reading
	input  oflow_pkg::frame_num_t  frame_num,
	input  oflow_pkg::hist_cnt_t   num_of_history_frames,
	// line counts per slot from writer
	input  oflow_pkg::end_ptrs_t   end_ptrs,
	// control pulses
	input  logic                   start_read,
	input  logic                   ready_new_line,
	// status to consumer
	output logic                   done_read,
	output oflow_pkg::frame_num_t  frame_to_read,
	output oflow_pkg::offset_t     offset_0,
	output oflow_pkg::hist_cnt_t   history_index,
	// to slot memory
	output logic                   rd_en,
	output oflow_pkg::rd_req_t     rd_req
);

	// ------------------------------
	// signals
	// ------------------------------

	oflow_pkg::read_state_t state;
	oflow_pkg::read_state_t next_state;

	oflow_pkg::hist_cnt_t   hist_cnt;
	oflow_pkg::hist_cnt_t   max_frames;
	oflow_pkg::offset_t     offset_cnt;
	oflow_pkg::frame_num_t  frame_cur;
	oflow_pkg::slot_t       rd_slot;
	oflow_pkg::line_cnt_t   cur_end;

	logic frame_done;
	logic empty_frame;
	logic last_line;
	logic next_rd;

	// ------------------------------
	// frame and slot selection
	// ------------------------------

	// early frames have fewer history entries
	assign max_frames = (frame_num < oflow_pkg::frame_num_t'(num_of_history_frames)) ?
		oflow_pkg::hist_cnt_t'(frame_num) : num_of_history_frames;

	// newest history frame first
	assign frame_cur = frame_num - 8'd1 - oflow_pkg::frame_num_t'(hist_cnt);
	assign rd_slot   = oflow_pkg::slot_t'(frame_cur % num_of_history_frames);
	assign cur_end   = end_ptrs[rd_slot];

	assign empty_frame = (cur_end == '0);
	// offset points at the frame's final line
	assign last_line = (oflow_pkg::line_cnt_t'(offset_cnt) + 7'd1 == cur_end);

	// ------------------------------
	// state register
	// ------------------------------

	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			state <= oflow_pkg::idle_st;
		end else begin
			state <= next_state;
		end
	end

	// next state, done and frame completion
	always_comb begin
		next_state = state;
		frame_done = 1'b0;
		done_read  = 1'b0;
		next_rd    = 1'b0;
		case (state)
			oflow_pkg::idle_st: begin
				if (start_read) begin
					next_state = oflow_pkg::frame_st;
				end
			end
			oflow_pkg::frame_st: begin
				if (hist_cnt < max_frames) begin
					next_state = oflow_pkg::offset_st;
					// first line of a non-empty frame
					next_rd = !empty_frame;
				end else begin
					next_state = oflow_pkg::idle_st;
					done_read  = 1'b1;
				end
			end
			oflow_pkg::offset_st: begin
				if (empty_frame) begin
					// nothing stored, skip
					next_state = oflow_pkg::frame_st;
					frame_done = 1'b1;
				end else if (ready_new_line) begin
					if (last_line) begin
						next_state = oflow_pkg::frame_st;
						frame_done = 1'b1;
					end else begin
						next_rd = 1'b1;
					end
				end
			end
			default: begin
				next_state = oflow_pkg::idle_st;
			end
		endcase
	end

	// ------------------------------
	// counters
	// ------------------------------

	// history index, back to 0 once the walk ends
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			hist_cnt <= '0;
		end else if (state == oflow_pkg::idle_st || done_read) begin
			hist_cnt <= '0;
		end else if (frame_done) begin
			hist_cnt <= hist_cnt + 3'd1;
		end
	end

	// line offset, holds while the consumer is busy
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			offset_cnt <= '0;
		end else if (state == oflow_pkg::idle_st || frame_done) begin
			offset_cnt <= '0;
		end else if (state == oflow_pkg::offset_st && next_rd) begin
			offset_cnt <= offset_cnt + 6'd1;
		end
	end

	// read strobe lines up with the updated offset
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			rd_en <= 1'b0;
		end else begin
			rd_en <= next_rd;
		end
	end

	// ------------------------------
	// outputs
	// ------------------------------

	assign rd_req.slot   = rd_slot;
	assign rd_req.offset = offset_cnt;

	// idle shows zero, not frame_num - 1
	assign frame_to_read = (state == oflow_pkg::idle_st) ? '0 : frame_cur;
	assign offset_0      = offset_cnt;
	assign history_index = hist_cnt;

	// ------------------------------
	// checks
	// ------------------------------

	a_done_pulse: assert property (@(posedge clk) disable iff (!reset_N)
		done_read |=> !done_read)
		else $error("ERR done_read held high, history_index=%h", hist_cnt);

	a_rd_in_offset: assert property (@(posedge clk) disable iff (!reset_N)
		rd_en |-> (state == oflow_pkg::offset_st))
		else $error("ERR rd_en in state %h", state);

endmodule

`default_nettype wire

//--- hw/oflow_mem_buffer.sv
/* optical flow history buffer
   frame writer, slot memory and read sequencer */
`timescale 1ns/10ps
`default_nettype none

module oflow_mem_buffer (
	input  logic                   clk,
	input  logic                   reset_N,
	// frame context
	input  oflow_pkg::frame_num_t  frame_num,
	input  oflow_pkg::hist_cnt_t   num_of_history_frames,
	// incoming frame
	input  logic                   line_in_valid,
	input  oflow_pkg::line_t       line_in,
	input  logic                   frame_end,
	// read control
	input  logic                   start_read,
	input  logic                   ready_new_line,
	// read status
	output logic                   done_read,
	output oflow_pkg::frame_num_t  frame_to_read,
	output oflow_pkg::offset_t     offset_0,
	output oflow_pkg::hist_cnt_t   history_index,
	// played back lines
	output oflow_pkg::line_t       line_out,
	output logic                   line_out_valid
);

	// ------------------------------
	// internal wires
	// ------------------------------

	// writer to memory
	logic                 wr_en;
	oflow_pkg::wr_req_t   wr_req;
	// writer to sequencer
	oflow_pkg::end_ptrs_t end_ptrs;
	// sequencer to memory
	logic                 rd_en;
	oflow_pkg::rd_req_t   rd_req;

	// write side
	oflow_frame_writer u_frame_writer (
		.clk                   (clk),
		.reset_N               (reset_N),
		.frame_num             (frame_num),
		.num_of_history_frames (num_of_history_frames),
		.line_in_valid         (line_in_valid),
		.line_in               (line_in),
		.frame_end             (frame_end),
		.wr_en                 (wr_en),
		.wr_req                (wr_req),
		.end_ptrs              (end_ptrs)
	);

	// storage, read data goes straight out
	oflow_frame_mem u_frame_mem (
		.clk      (clk),
		.reset_N  (reset_N),
		.wr_en    (wr_en),
		.wr_req   (wr_req),
		.rd_en    (rd_en),
		.rd_req   (rd_req),
		.rd_data  (line_out),
		.rd_valid (line_out_valid)
	);

	// read side
	oflow_fsm_read u_fsm_read (
		.clk                   (clk),
		.reset_N               (reset_N),
		.frame_num             (frame_num),
		.num_of_history_frames (num_of_history_frames),
		.end_ptrs              (end_ptrs),
		.start_read            (start_read),
		.ready_new_line        (ready_new_line),
		.done_read             (done_read),
		.frame_to_read         (frame_to_read),
		.offset_0              (offset_0),
		.history_index         (history_index),
		.rd_en                 (rd_en),
		.rd_req                (rd_req)
	);

endmodule

`default_nettype wire

//--- sim/oflow_tb.sv
/* history buffer testbench
   writes frames, plays them back and checks every beat against a slot model */
`timescale 1ns/10ps
`default_nettype none

`include "oflow_macros.svh"

module oflow_tb;

	// ------------------------------
	// run limits
	// ------------------------------

	localparam int MAX_LINES = 20;
	localparam int MAX_DELAY = 7;
	// 17 frames written and 20 frames read over all tests
	localparam int WATCHDOG_CYCLES = (17 + 20) * MAX_LINES * (MAX_DELAY + 1) * 2 + 200;

	// one expected beat
	typedef struct packed {
		oflow_pkg::frame_num_t frame;
		oflow_pkg::hist_cnt_t  hist;
		oflow_pkg::offset_t    offset;
		oflow_pkg::line_t      data;
	} exp_beat_t;

	logic                  clk;
	logic                  reset_N;
	oflow_pkg::frame_num_t frame_num;
	oflow_pkg::hist_cnt_t  num_of_history_frames;
	logic                  line_in_valid;
	oflow_pkg::line_t      line_in;
	logic                  frame_end;
	logic                  start_read;
	logic                  ready_new_line;
	logic                  done_read;
	oflow_pkg::frame_num_t frame_to_read;
	oflow_pkg::offset_t    offset_0;
	oflow_pkg::hist_cnt_t  history_index;
	oflow_pkg::line_t      line_out;
	logic                  line_out_valid;

	// slot model mirroring what the writer should hold
	oflow_pkg::line_t     model_mem [`OFLOW_HIST_SLOTS][`OFLOW_LINE_DEPTH];
	oflow_pkg::line_cnt_t model_end [`OFLOW_HIST_SLOTS];

	// scoreboard with a head copy that only changes on falling edges
	exp_beat_t exp_q[$];
	exp_beat_t head;
	logic      q_empty;
	logic      pop_next;

	// consumer wait window and idle window
	logic                  waiting;
	logic                  idle_chk;
	oflow_pkg::offset_t    hold_offset;
	oflow_pkg::frame_num_t hold_frame;

	int err_cnt;
	int test_cnt;
	int pass_cnt;
	int test_err_base;

	oflow_mem_buffer dut (
		.clk                   (clk),
		.reset_N               (reset_N),
		.frame_num             (frame_num),
		.num_of_history_frames (num_of_history_frames),
		.line_in_valid         (line_in_valid),
		.line_in               (line_in),
		.frame_end             (frame_end),
		.start_read            (start_read),
		.ready_new_line        (ready_new_line),
		.done_read             (done_read),
		.frame_to_read         (frame_to_read),
		.offset_0              (offset_0),
		.history_index         (history_index),
		.line_out              (line_out),
		.line_out_valid        (line_out_valid)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// ------------------------------
	// scoreboard upkeep
	// ------------------------------

	function automatic void update_head();
		q_empty = (exp_q.size() == 0);
		if (!q_empty) begin
			head = exp_q[0];
		end
	endfunction

	// beat checked on the rising edge and dropped one falling edge later
	always @(negedge clk) begin
		if (pop_next && exp_q.size() > 0) begin
			void'(exp_q.pop_front());
			update_head();
		end
		pop_next = line_out_valid;
	end

	// ------------------------------
	// checks
	// ------------------------------

	a_beat_expected: assert property (@(posedge clk) disable iff (!reset_N)
		line_out_valid |-> !q_empty)
		else begin
			$display("line_out_valid beat arrived with no line left to read");
			err_cnt = err_cnt + 1;
		end

	a_line_data: assert property (@(posedge clk) disable iff (!reset_N)
		(line_out_valid && !q_empty) |-> (line_out == head.data))
		else begin
			$display("ERR line_out=%h expected=%h", line_out, head.data);
			err_cnt = err_cnt + 1;
		end

	a_line_frame: assert property (@(posedge clk) disable iff (!reset_N)
		(line_out_valid && !q_empty) |-> (frame_to_read == head.frame))
		else begin
			$display("ERR frame_to_read=%h expected=%h", frame_to_read, head.frame);
			err_cnt = err_cnt + 1;
		end

	a_line_hist: assert property (@(posedge clk) disable iff (!reset_N)
		(line_out_valid && !q_empty) |-> (history_index == head.hist))
		else begin
			$display("ERR history_index=%h expected=%h", history_index, head.hist);
			err_cnt = err_cnt + 1;
		end

	a_line_offset: assert property (@(posedge clk) disable iff (!reset_N)
		(line_out_valid && !q_empty) |-> (offset_0 == head.offset))
		else begin
			$display("ERR offset_0=%h expected=%h", offset_0, head.offset);
			err_cnt = err_cnt + 1;
		end

	// outputs frozen while the consumer is busy
	a_hold: assert property (@(posedge clk) disable iff (!reset_N)
		waiting |-> (offset_0 == hold_offset && frame_to_read == hold_frame))
		else begin
			$display("ERR offset_0=%h frame_to_read=%h expected=%h %h while waiting",
				offset_0, frame_to_read, hold_offset, hold_frame);
			err_cnt = err_cnt + 1;
		end

	a_done_empty: assert property (@(posedge clk) disable iff (!reset_N)
		done_read |-> q_empty)
		else begin
			$display("done_read came with %0d expected lines still missing", exp_q.size());
			err_cnt = err_cnt + 1;
		end

	a_idle_quiet: assert property (@(posedge clk) disable iff (!reset_N)
		idle_chk |-> (!done_read && !line_out_valid))
		else begin
			$display("done_read or line_out_valid went high with no stimulus");
			err_cnt = err_cnt + 1;
		end

	a_idle_zero: assert property (@(posedge clk) disable iff (!reset_N)
		idle_chk |-> (frame_to_read == '0 && offset_0 == '0 && history_index == '0))
		else begin
			$display("ERR frame_to_read=%h offset_0=%h history_index=%h expected 0",
				frame_to_read, offset_0, history_index);
			err_cnt = err_cnt + 1;
		end

	// ------------------------------
	// stimulus tasks
	// ------------------------------

	// writes one frame into slot fnum mod nhist right after a rising edge
	task automatic write_frame(input oflow_pkg::frame_num_t fnum,
		input oflow_pkg::hist_cnt_t nhist, input int nlines);
		oflow_pkg::slot_t slot;
		oflow_pkg::line_t word;
		int i;
		slot = oflow_pkg::slot_t'(int'(fnum) % int'(nhist));
		frame_num <= fnum;
		num_of_history_frames <= nhist;
		@(posedge clk);
		for (i = 0; i < nlines; i++) begin
			word = $urandom;
			line_in_valid <= 1'b1;
			line_in <= word;
			model_mem[slot][i] = word;
			@(posedge clk);
		end
		line_in_valid <= 1'b0;
		frame_end <= 1'b1;
		@(posedge clk);
		frame_end <= 1'b0;
		model_end[slot] = oflow_pkg::line_cnt_t'(nlines);
	endtask

	// expected beats newest frame first and then the consumer loop
	task automatic read_history(input oflow_pkg::frame_num_t fnum,
		input oflow_pkg::hist_cnt_t nhist, input int max_delay);
		oflow_pkg::frame_num_t f;
		oflow_pkg::slot_t      slot;
		exp_beat_t             beat;
		int                    h;
		int                    o;
		int                    nframes;
		int                    delay;
		logic                  done;
		nframes = (int'(fnum) < int'(nhist)) ? int'(fnum) : int'(nhist);
		frame_num <= fnum;
		num_of_history_frames <= nhist;
		@(negedge clk);
		for (h = 0; h < nframes; h++) begin
			f = fnum - 8'd1 - oflow_pkg::frame_num_t'(h);
			slot = oflow_pkg::slot_t'(int'(f) % int'(nhist));
			// empty slots add nothing
			for (o = 0; o < int'(model_end[slot]); o++) begin
				beat.frame = f;
				beat.hist = oflow_pkg::hist_cnt_t'(h);
				beat.offset = oflow_pkg::offset_t'(o);
				beat.data = model_mem[slot][o];
				exp_q.push_back(beat);
			end
		end
		update_head();
		@(posedge clk);
		start_read <= 1'b1;
		@(posedge clk);
		start_read <= 1'b0;
		done = 1'b0;
		while (!done) begin
			@(negedge clk);
			if (done_read) begin
				done = 1'b1;
			end else if (line_out_valid) begin
				hold_offset = offset_0;
				hold_frame = frame_to_read;
				waiting = 1'b1;
				delay = $urandom_range(max_delay, 0);
				repeat (delay) @(negedge clk);
				@(posedge clk);
				ready_new_line <= 1'b1;
				@(negedge clk);
				waiting = 1'b0;
				@(posedge clk);
				ready_new_line <= 1'b0;
			end
		end
		// late beats would still hit the checks
		repeat (4) @(posedge clk);
	endtask

	task automatic end_test(input string name);
		int errs;
		errs = err_cnt - test_err_base;
		test_cnt = test_cnt + 1;
		if (errs == 0) begin
			pass_cnt = pass_cnt + 1;
			$display("test %0d %s: ok", test_cnt, name);
		end else begin
			$display("test %0d %s: %0d errors", test_cnt, name, errs);
		end
		test_err_base = err_cnt;
	endtask

	// ------------------------------
	// watchdog
	// ------------------------------

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("run stopped, tests did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("Simulation FAILED");
		$finish;
	end

	// ------------------------------
	// test sequence
	// ------------------------------

	initial begin
		void'($urandom(32'h1e80_02f4));
		reset_N = 1'b0;
		frame_num = '0;
		num_of_history_frames = 3'd5;
		line_in_valid = 1'b0;
		line_in = '0;
		frame_end = 1'b0;
		start_read = 1'b0;
		ready_new_line = 1'b0;
		q_empty = 1'b1;
		head = '0;
		pop_next = 1'b0;
		waiting = 1'b0;
		idle_chk = 1'b0;
		hold_offset = '0;
		hold_frame = '0;
		err_cnt = 0;
		test_cnt = 0;
		pass_cnt = 0;
		test_err_base = 0;
		for (int s = 0; s < `OFLOW_HIST_SLOTS; s++) begin
			model_end[s] = '0;
		end
		repeat (3) @(posedge clk);
		reset_N <= 1'b1;

		// quiet after reset
		@(negedge clk);
		idle_chk = 1'b1;
		repeat (20) @(negedge clk);
		idle_chk = 1'b0;
		@(posedge clk);
		end_test("idle after reset");

		// full ring of five
		for (int n = 0; n < 5; n++) begin
			write_frame(oflow_pkg::frame_num_t'(n), 3'd5, $urandom_range(MAX_LINES, 1));
		end
		read_history(8'd5, 3'd5, 0);
		end_test("five frames newest first");

		// fewer frames than slots
		read_history(8'd2, 3'd5, 0);
		end_test("frame_num below history count");

		// frames 6 and 8 left empty
		write_frame(8'd5, 3'd5, $urandom_range(MAX_LINES, 1));
		write_frame(8'd6, 3'd5, 0);
		write_frame(8'd7, 3'd5, $urandom_range(MAX_LINES, 1));
		write_frame(8'd8, 3'd5, 0);
		write_frame(8'd9, 3'd5, $urandom_range(MAX_LINES, 1));
		read_history(8'd10, 3'd5, 0);
		end_test("empty frames skipped");

		read_history(8'd10, 3'd5, MAX_DELAY);
		end_test("random consumer delays");

		// seven frames overwrite the older slots of a three slot ring
		for (int n = 10; n < 17; n++) begin
			write_frame(oflow_pkg::frame_num_t'(n), 3'd3, $urandom_range(MAX_LINES, 1));
		end
		read_history(8'd17, 3'd3, 3);
		end_test("three slot ring overwrite");

		$display("tests %0d, passed %0d, failed %0d, errors %0d",
			test_cnt, pass_cnt, test_cnt - pass_cnt, err_cnt);
		if (err_cnt == 0 && pass_cnt == test_cnt) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- build.f
+incdir+hw
hw/oflow_pkg.sv
hw/oflow_frame_writer.sv
hw/oflow_frame_mem.sv
hw/oflow_fsm_read.sv
hw/oflow_mem_buffer.sv
sim/oflow_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the history buffer testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module oflow_tb \
	--Mdir "$BUILD_DIR" -o oflow_sim \
	-f build.f

# the log decides the result, not the exit status
"./$BUILD_DIR/oflow_sim" > "$LOG" 2>&1 || true
cat "$LOG"

if grep -qF "Simulation PASSED" "$LOG"; then
	echo "result: pass"
else
	echo "result: fail"
	exit 1
fi
